// File: design/cpu_ctrl_pkg.sv
// CPU control package
// Shared widths, opcodes, ALU operation codes and the control word layout
`default_nettype none

package cpu_ctrl_pkg;

  // Micro-step counter width, enough for 32 steps
  localparam int STEP_W = 5;

  // Every instruction starts with the same two fetch steps
  localparam int FETCH_STEPS = 2;

  // Opcodes are 16-bit constants and are zero-extended to the instruction width
  localparam int OPCODE_W = 16;

  typedef enum logic [OPCODE_W-1:0] {
    OP_NOP     = 16'h0000, OP_LD_A    = 16'h0001, OP_LD_B    = 16'h0002,
    OP_LD_C    = 16'h0003, OP_ST_A    = 16'h0004, OP_ST_T    = 16'h0005,
    OP_ST_B    = 16'h0006, OP_ST_C    = 16'h0007, OP_LDT_A   = 16'h0008,
    OP_LDT_B   = 16'h0009, OP_LDT_C   = 16'h000a, OP_STT_A   = 16'h000b,
    OP_STT_B   = 16'h000c, OP_STT_C   = 16'h000d, OP_MOV_A_T = 16'h000e,
    OP_MOV_A_B = 16'h000f, OP_MOV_A_C = 16'h0010, OP_MOV_T_A = 16'h0011,
    OP_MOV_T_B = 16'h0012, OP_MOV_T_C = 16'h0013, OP_MOV_B_A = 16'h0014,
    OP_MOV_B_T = 16'h0015, OP_MOV_B_C = 16'h0016, OP_MOV_C_A = 16'h0017,
    OP_MOV_C_T = 16'h0018, OP_MOV_C_B = 16'h0019,
    // 0x1a to 0x25 are unassigned and fall through to NOP
    OP_OUT_A   = 16'h0026, OP_OUT_T   = 16'h0027, OP_OUT_B   = 16'h0028,
    OP_OUT_C   = 16'h0029, OP_LDI_A   = 16'h002a, OP_LDI_B   = 16'h002b,
    OP_LDI_C   = 16'h002c, OP_JMP     = 16'h002d, OP_JIZ     = 16'h002e,
    OP_JIC     = 16'h002f, OP_JIO     = 16'h0030, OP_ADDI    = 16'h0031,
    OP_SUBI    = 16'h0032, OP_ANDI    = 16'h0033, OP_ORI     = 16'h0034,
    OP_XORI    = 16'h0035, OP_ADD_B   = 16'h0036, OP_SUB_B   = 16'h0037,
    OP_AND_B   = 16'h0038, OP_OR_B    = 16'h0039, OP_XOR_B   = 16'h003a,
    OP_ADD_C   = 16'h003b, OP_SUB_C   = 16'h003c, OP_AND_C   = 16'h003d,
    OP_OR_C    = 16'h003e, OP_XOR_C   = 16'h003f, OP_SL      = 16'h0040,
    OP_SR      = 16'h0041, OP_ASR     = 16'h0042, OP_ROL     = 16'h0043,
    OP_ROR     = 16'h0044, OP_ROLC    = 16'h0045, OP_RORC    = 16'h0046,
    OP_INV     = 16'h0047, OP_NEG     = 16'h0048, OP_CHK     = 16'h0049,
    OP_HLT     = 16'hffff
  } op_e;

  typedef enum logic [3:0] {
    ALU_NONE = 4'h0, ALU_ADD  = 4'h1, ALU_SUB  = 4'h2, ALU_AND  = 4'h3,
    ALU_OR   = 4'h4, ALU_XOR  = 4'h5, ALU_SL   = 4'h6, ALU_SR   = 4'h7,
    ALU_ASR  = 4'h8, ALU_ROL  = 4'h9, ALU_ROR  = 4'ha, ALU_ROLC = 4'hb,
    ALU_RORC = 4'hc, ALU_INV  = 4'hd, ALU_NEG  = 4'he, ALU_CHK  = 4'hf
  } alu_op_e;

  // Control word, 20 strobes plus the ALU operation field
  // Register strobes a_ri .. t_ro correspond to ARI .. TRO
  typedef struct packed {
    logic    mi;
    logic    co;
    logic    ro;
    logic    ri;
    logic    ii;
    logic    ce;
    logic    j;
    logic    a_ri;
    logic    a_ro;
    logic    b_ri;
    logic    b_ro;
    logic    c_ri;
    logic    c_ro;
    logic    t_ri;
    logic    t_ro;
    logic    oi;
    logic    eo;
    logic    el;
    logic    hlt;
    logic    adv;
    alu_op_e alu;
  } ctrl_word_t;

  localparam ctrl_word_t CTRL_IDLE = '0;

endpackage

`default_nettype wire

// File: design/decode_if.sv
// Decode bus
// Opcode, micro-step and ALU flags shared by the step counter and the decoders
`timescale 1ns/1ns
`default_nettype none

interface decode_if #(
  parameter int INSTR_W = 16
);
  import cpu_ctrl_pkg::*;

  logic [INSTR_W-1:0] instruction;
  logic [STEP_W-1:0]  step;
  logic               zero;
  logic               carry;
  logic               odd;

  modport counter (output step);

  modport decoder (input instruction, input step, input zero, input carry, input odd);

endinterface

`default_nettype wire

// File: design/step_counter.sv
// Micro-step counter
// Restarts on ADV, holds on HLT and otherwise advances one step per clock
`timescale 1ns/1ns
`default_nettype none

module step_counter (
  input  wire          i_clk,
  input  wire          i_rst_n,
  input  wire          i_advance,
  input  wire          i_halt,
  decode_if.counter    cnt
);
  import cpu_ctrl_pkg::*;

  logic [STEP_W-1:0] step_q;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      step_q <= '0;
    end else if (i_advance) begin
      // Last step of the instruction, go back to fetch
      step_q <= '0;
    end else if (!i_halt) begin
      step_q <= step_q + STEP_W'(1);
    end
  end

  assign cnt.step = step_q;

endmodule

`default_nettype wire

// File: design/transfer_decoder.sv
// Transfer microcode
// Direct, immediate and T-indirect loads and stores, register moves and OUT
`timescale 1ns/1ns
`default_nettype none

module transfer_decoder #(
  parameter int INSTR_W = 16
) (
  decode_if.decoder                dec,
  output cpu_ctrl_pkg::ctrl_word_t o_word,
  output logic                     o_hit
);
  import cpu_ctrl_pkg::*;

  typedef enum logic [2:0] {K_NONE, K_LOAD, K_STORE, K_LOAD_T, K_STORE_T, K_MOVE} kind_e;

  // R_O is the output port, only valid as a destination
  typedef enum logic [2:0] {R_A, R_T, R_B, R_C, R_O} reg_e;

  typedef struct packed {
    kind_e kind;
    reg_e  src;
    reg_e  dst;
  } xfer_t;

  xfer_t info;

  function automatic ctrl_word_t in_word(reg_e r);
    ctrl_word_t w;
    w = CTRL_IDLE;
    case (r)
      R_A:     w.a_ri = 1'b1;
      R_T:     w.t_ri = 1'b1;
      R_B:     w.b_ri = 1'b1;
      R_C:     w.c_ri = 1'b1;
      default: w.oi   = 1'b1;
    endcase
    return w;
  endfunction

  function automatic ctrl_word_t out_word(reg_e r);
    ctrl_word_t w;
    w = CTRL_IDLE;
    case (r)
      R_A:     w.a_ro = 1'b1;
      R_T:     w.t_ro = 1'b1;
      R_B:     w.b_ro = 1'b1;
      R_C:     w.c_ro = 1'b1;
      default: w = CTRL_IDLE;
    endcase
    return w;
  endfunction

  // Immediate loads share the direct load sequence
  always_comb begin
    info = '{K_NONE, R_A, R_A};
    case (dec.instruction)
      INSTR_W'(OP_LD_A), INSTR_W'(OP_LDI_A): info = '{K_LOAD, R_A, R_A};
      INSTR_W'(OP_LD_B), INSTR_W'(OP_LDI_B): info = '{K_LOAD, R_A, R_B};
      INSTR_W'(OP_LD_C), INSTR_W'(OP_LDI_C): info = '{K_LOAD, R_A, R_C};
      INSTR_W'(OP_ST_A):    info = '{K_STORE, R_A, R_A};
      INSTR_W'(OP_ST_T):    info = '{K_STORE, R_T, R_A};
      INSTR_W'(OP_ST_B):    info = '{K_STORE, R_B, R_A};
      INSTR_W'(OP_ST_C):    info = '{K_STORE, R_C, R_A};
      INSTR_W'(OP_LDT_A):   info = '{K_LOAD_T, R_A, R_A};
      INSTR_W'(OP_LDT_B):   info = '{K_LOAD_T, R_A, R_B};
      INSTR_W'(OP_LDT_C):   info = '{K_LOAD_T, R_A, R_C};
      INSTR_W'(OP_STT_A):   info = '{K_STORE_T, R_A, R_A};
      INSTR_W'(OP_STT_B):   info = '{K_STORE_T, R_B, R_A};
      INSTR_W'(OP_STT_C):   info = '{K_STORE_T, R_C, R_A};
      INSTR_W'(OP_MOV_A_T): info = '{K_MOVE, R_A, R_T};
      INSTR_W'(OP_MOV_A_B): info = '{K_MOVE, R_A, R_B};
      INSTR_W'(OP_MOV_A_C): info = '{K_MOVE, R_A, R_C};
      INSTR_W'(OP_MOV_T_A): info = '{K_MOVE, R_T, R_A};
      INSTR_W'(OP_MOV_T_B): info = '{K_MOVE, R_T, R_B};
      INSTR_W'(OP_MOV_T_C): info = '{K_MOVE, R_T, R_C};
      INSTR_W'(OP_MOV_B_A): info = '{K_MOVE, R_B, R_A};
      INSTR_W'(OP_MOV_B_T): info = '{K_MOVE, R_B, R_T};
      INSTR_W'(OP_MOV_B_C): info = '{K_MOVE, R_B, R_C};
      INSTR_W'(OP_MOV_C_A): info = '{K_MOVE, R_C, R_A};
      INSTR_W'(OP_MOV_C_T): info = '{K_MOVE, R_C, R_T};
      INSTR_W'(OP_MOV_C_B): info = '{K_MOVE, R_C, R_B};
      INSTR_W'(OP_OUT_A):   info = '{K_MOVE, R_A, R_O};
      INSTR_W'(OP_OUT_T):   info = '{K_MOVE, R_T, R_O};
      INSTR_W'(OP_OUT_B):   info = '{K_MOVE, R_B, R_O};
      INSTR_W'(OP_OUT_C):   info = '{K_MOVE, R_C, R_O};
      default:              info = '{K_NONE, R_A, R_A};
    endcase
  end

  always_comb begin
    o_word = CTRL_IDLE;
    if (dec.step == STEP_W'(2)) begin
      case (info.kind)
        K_LOAD, K_STORE: begin
          // Address word follows the opcode
          o_word.mi = 1'b1;
          o_word.co = 1'b1;
          o_word.ce = 1'b1;
        end
        K_LOAD_T, K_STORE_T: begin
          o_word.mi   = 1'b1;
          o_word.t_ro = 1'b1;
        end
        K_MOVE: begin
          o_word     = out_word(info.src) | in_word(info.dst);
          o_word.adv = 1'b1;
        end
        default: o_word = CTRL_IDLE;
      endcase
    end else if (dec.step == STEP_W'(3)) begin
      if (info.kind == K_LOAD || info.kind == K_LOAD_T) begin
        o_word     = in_word(info.dst);
        o_word.ro  = 1'b1;
        o_word.adv = 1'b1;
      end else if (info.kind == K_STORE || info.kind == K_STORE_T) begin
        o_word     = out_word(info.src);
        o_word.ri  = 1'b1;
        o_word.adv = 1'b1;
      end
    end
  end

  assign o_hit = (info.kind != K_NONE);

endmodule

`default_nettype wire

// File: design/alu_decoder.sv
// ALU microcode
// Immediate, register and single-operand ALU instructions, result lands in T
`timescale 1ns/1ns
`default_nettype none

module alu_decoder #(
  parameter int INSTR_W = 16
) (
  decode_if.decoder                dec,
  output cpu_ctrl_pkg::ctrl_word_t o_word,
  output logic                     o_hit
);
  import cpu_ctrl_pkg::*;

  typedef enum logic [2:0] {F_NONE, F_IMM, F_REG_B, F_REG_C, F_UNARY} form_e;

  form_e             form;
  alu_op_e           op;
  logic [STEP_W-1:0] op_step;

  always_comb begin
    form = F_NONE;
    op   = ALU_NONE;
    case (dec.instruction)
      INSTR_W'(OP_ADDI):  {form, op} = {F_IMM, ALU_ADD};
      INSTR_W'(OP_SUBI):  {form, op} = {F_IMM, ALU_SUB};
      INSTR_W'(OP_ANDI):  {form, op} = {F_IMM, ALU_AND};
      INSTR_W'(OP_ORI):   {form, op} = {F_IMM, ALU_OR};
      INSTR_W'(OP_XORI):  {form, op} = {F_IMM, ALU_XOR};
      INSTR_W'(OP_ADD_B): {form, op} = {F_REG_B, ALU_ADD};
      INSTR_W'(OP_SUB_B): {form, op} = {F_REG_B, ALU_SUB};
      INSTR_W'(OP_AND_B): {form, op} = {F_REG_B, ALU_AND};
      INSTR_W'(OP_OR_B):  {form, op} = {F_REG_B, ALU_OR};
      INSTR_W'(OP_XOR_B): {form, op} = {F_REG_B, ALU_XOR};
      INSTR_W'(OP_ADD_C): {form, op} = {F_REG_C, ALU_ADD};
      INSTR_W'(OP_SUB_C): {form, op} = {F_REG_C, ALU_SUB};
      INSTR_W'(OP_AND_C): {form, op} = {F_REG_C, ALU_AND};
      INSTR_W'(OP_OR_C):  {form, op} = {F_REG_C, ALU_OR};
      INSTR_W'(OP_XOR_C): {form, op} = {F_REG_C, ALU_XOR};
      INSTR_W'(OP_SL):    {form, op} = {F_UNARY, ALU_SL};
      INSTR_W'(OP_SR):    {form, op} = {F_UNARY, ALU_SR};
      INSTR_W'(OP_ASR):   {form, op} = {F_UNARY, ALU_ASR};
      INSTR_W'(OP_ROL):   {form, op} = {F_UNARY, ALU_ROL};
      INSTR_W'(OP_ROR):   {form, op} = {F_UNARY, ALU_ROR};
      INSTR_W'(OP_ROLC):  {form, op} = {F_UNARY, ALU_ROLC};
      INSTR_W'(OP_RORC):  {form, op} = {F_UNARY, ALU_RORC};
      INSTR_W'(OP_INV):   {form, op} = {F_UNARY, ALU_INV};
      INSTR_W'(OP_NEG):   {form, op} = {F_UNARY, ALU_NEG};
      INSTR_W'(OP_CHK):   {form, op} = {F_UNARY, ALU_CHK};
      default:            {form, op} = {F_NONE, ALU_NONE};
    endcase
  end

  // The operation step comes after whatever it takes to get the operand into T
  assign op_step = (form == F_IMM)   ? STEP_W'(4) :
                   (form == F_UNARY) ? STEP_W'(2) : STEP_W'(3);

  always_comb begin
    o_word = CTRL_IDLE;
    if (form != F_NONE && dec.step == op_step) begin
      o_word.eo   = 1'b1;
      o_word.t_ri = 1'b1;
      o_word.el   = 1'b1;
      o_word.adv  = 1'b1;
      o_word.alu  = op;
    end else if (dec.step == STEP_W'(2)) begin
      o_word.mi   = (form == F_IMM);
      o_word.co   = (form == F_IMM);
      o_word.ce   = (form == F_IMM);
      o_word.b_ro = (form == F_REG_B);
      o_word.c_ro = (form == F_REG_C);
      o_word.t_ri = (form == F_REG_B) || (form == F_REG_C);
    end else if (form == F_IMM && dec.step == STEP_W'(3)) begin
      // Immediate operand from memory into T
      o_word.ro   = 1'b1;
      o_word.t_ri = 1'b1;
    end
  end

  assign o_hit = (form != F_NONE);

endmodule

`default_nettype wire

// File: design/branch_decoder.sv
// Branch microcode
// JMP, the flag-conditional jumps and HLT
`timescale 1ns/1ns
`default_nettype none

module branch_decoder #(
  parameter int INSTR_W = 16
) (
  decode_if.decoder                dec,
  output cpu_ctrl_pkg::ctrl_word_t o_word,
  output logic                     o_hit
);
  import cpu_ctrl_pkg::*;

  logic is_jump;
  logic is_halt;
  logic taken;

  always_comb begin
    is_jump = 1'b1;
    is_halt = 1'b0;
    taken   = 1'b1;
    case (dec.instruction)
      INSTR_W'(OP_JMP): taken = 1'b1;
      INSTR_W'(OP_JIZ): taken = dec.zero;
      INSTR_W'(OP_JIC): taken = dec.carry;
      INSTR_W'(OP_JIO): taken = dec.odd;
      INSTR_W'(OP_HLT): begin
        is_jump = 1'b0;
        is_halt = 1'b1;
      end
      default: is_jump = 1'b0;
    endcase
  end

  always_comb begin
    o_word = CTRL_IDLE;
    if (is_jump && dec.step == STEP_W'(2)) begin
      o_word.mi  = 1'b1;
      o_word.co  = 1'b1;
      o_word.ce  = 1'b1;
      // Not taken, the target word is skipped and the instruction ends here
      o_word.adv = ~taken;
    end else if (is_jump && dec.step == STEP_W'(3)) begin
      o_word.ro  = 1'b1;
      o_word.j   = 1'b1;
      o_word.adv = 1'b1;
    end else if (is_halt && dec.step == STEP_W'(2)) begin
      o_word.hlt = 1'b1;
    end
  end

  assign o_hit = is_jump | is_halt;

endmodule

`default_nettype wire

// File: design/microcode_sequencer.sv
// Microcode sequencer
// Step counter plus class decoders, producing one control word per micro-step
`timescale 1ns/1ns
`default_nettype none

module microcode_sequencer #(
  parameter int INSTR_W = 16
) (
  input  wire                              i_clk,
  input  wire                              i_rst_n,
  input  wire  [INSTR_W-1:0]               i_instruction,
  input  wire                              i_zero,
  input  wire                              i_carry,
  input  wire                              i_odd,
  output logic [cpu_ctrl_pkg::STEP_W-1:0]  o_step,
  output cpu_ctrl_pkg::ctrl_word_t         o_control_word
);
  import cpu_ctrl_pkg::*;

  ctrl_word_t ctrl_word;
  ctrl_word_t xfer_word;
  ctrl_word_t alu_word;
  ctrl_word_t br_word;
  logic       xfer_hit;
  logic       alu_hit;
  logic       br_hit;

  decode_if #(.INSTR_W(INSTR_W)) dec_bus ();

  assign dec_bus.instruction = i_instruction;
  assign dec_bus.zero        = i_zero;
  assign dec_bus.carry       = i_carry;
  assign dec_bus.odd         = i_odd;

  step_counter u_step_counter (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_advance (ctrl_word.adv),
    .i_halt    (ctrl_word.hlt),
    .cnt       (dec_bus.counter)
  );

  transfer_decoder #(.INSTR_W(INSTR_W)) u_transfer_decoder (
    .dec    (dec_bus.decoder),
    .o_word (xfer_word),
    .o_hit  (xfer_hit)
  );

  alu_decoder #(.INSTR_W(INSTR_W)) u_alu_decoder (
    .dec    (dec_bus.decoder),
    .o_word (alu_word),
    .o_hit  (alu_hit)
  );

  branch_decoder #(.INSTR_W(INSTR_W)) u_branch_decoder (
    .dec    (dec_bus.decoder),
    .o_word (br_word),
    .o_hit  (br_hit)
  );

  always_comb begin
    ctrl_word = CTRL_IDLE;
    if (dec_bus.step == STEP_W'(0)) begin
      // PC to memory address
      ctrl_word.mi = 1'b1;
      ctrl_word.co = 1'b1;
    end else if (dec_bus.step == STEP_W'(1)) begin
      // Instruction register load, PC advance
      ctrl_word.ro = 1'b1;
      ctrl_word.ii = 1'b1;
      ctrl_word.ce = 1'b1;
    end else if (xfer_hit | alu_hit | br_hit) begin
      // Decoders that miss drive an idle word, so OR-ing is a clean select
      ctrl_word = xfer_word | alu_word | br_word;
    end else if (dec_bus.step == STEP_W'(FETCH_STEPS)) begin
      // Unknown opcode runs as NOP
      ctrl_word.adv = 1'b1;
    end
  end

  assign o_step         = dec_bus.step;
  assign o_control_word = ctrl_word;

endmodule

`default_nettype wire

// File: verification/sequencer_checker.sv
// Sequencer assertions
// Step counter and control word rules, bound to the sequencer top level
`timescale 1ns/1ns
`default_nettype none

module sequencer_checker (
  input wire                             i_clk,
  input wire                             i_rst_n,
  input wire [cpu_ctrl_pkg::STEP_W-1:0]  i_step,
  input wire cpu_ctrl_pkg::ctrl_word_t   i_word
);
  import cpu_ctrl_pkg::*;

  int assert_errors = 0;

  // ADV closes the instruction, so the next cycle is the first fetch step
  a_adv_restart: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_word.adv |=> (i_step == '0))
    else begin
      $error("ADV was not followed by step 0");
      assert_errors++;
    end

  a_hlt_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_word.hlt |=> (i_step == $past(i_step)))
    else begin
      $error("HLT did not hold the step");
      assert_errors++;
    end

  a_adv_hlt_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(i_word.adv && i_word.hlt))
    else begin
      $error("ADV and HLT active in the same word");
      assert_errors++;
    end

  // The longest instruction, an immediate ALU operation, ends at step 4
  a_step_max: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_step <= STEP_W'(4))
    else begin
      $error("Step went past 4");
      assert_errors++;
    end

endmodule

`default_nettype wire

// File: verification/sequencer_monitor.sv
// Sequencer monitor
// Compares each micro-step of a test with its expected word and length
`timescale 1ns/1ns
`default_nettype none

module sequencer_monitor #(
  parameter int HOLD_CYCLES = 12
) (
  input wire                             i_clk,
  input wire [cpu_ctrl_pkg::STEP_W-1:0]  i_step,
  input wire cpu_ctrl_pkg::ctrl_word_t   i_word,
  input wire [15:0]                      i_opcode,
  input wire signed [31:0]               i_test_id,
  input wire [7:0]                       i_exp_len,
  input wire [23:0]                      i_exp_w2,
  input wire [23:0]                      i_exp_w3,
  input wire [23:0]                      i_exp_w4,
  output int                             o_done,
  output int                             o_passed,
  output int                             o_failed
);
  import cpu_ctrl_pkg::*;

  // Fetch words MI|CO and RO|II|CE
  localparam logic [23:0] FETCH_ADDR = (24'h1 << 23) | (24'h1 << 22);
  localparam logic [23:0] FETCH_LOAD = (24'h1 << 21) | (24'h1 << 19) | (24'h1 << 18);

  int          last_id = -1;
  int          cyc = 0;
  int          errs = 0;
  int          idx;
  bit          open = 1'b0;
  bit          hold;
  logic [23:0] exp_word;
  int          done_cnt = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;

  assign o_done   = done_cnt;
  assign o_passed = pass_cnt;
  assign o_failed = fail_cnt;

  // Sample on the falling edge, half a cycle away from stimulus and state changes
  always @(negedge i_clk) begin
    if (i_test_id != last_id) begin
      last_id = i_test_id;
      cyc     = 0;
      errs    = 0;
      open    = 1'b1;
    end
    if (i_test_id >= 0 && open) begin
      // A length of zero marks a halt test, which must sit at step 2
      hold = (i_exp_len == 8'd0);
      idx  = (hold && cyc > 2) ? 2 : ((cyc > 4) ? 4 : cyc);
      case (idx)
        0:       exp_word = FETCH_ADDR;
        1:       exp_word = FETCH_LOAD;
        2:       exp_word = i_exp_w2;
        3:       exp_word = i_exp_w3;
        default: exp_word = i_exp_w4;
      endcase
      if (i_step !== STEP_W'(idx)) begin
        $display("Fail test %0d cycle %0d: o_step = 0x%0h, expected 0x%0h",
                 i_test_id, cyc, i_step, idx);
        errs++;
      end
      if (i_word !== exp_word) begin
        $display("Fail test %0d cycle %0d: o_control_word = 0x%06h, expected 0x%06h",
                 i_test_id, cyc, i_word, exp_word);
        errs++;
      end
      if (hold ? (cyc == HOLD_CYCLES - 1) : (i_word.adv === 1'b1)) begin
        if (!hold && cyc + 1 != i_exp_len) begin
          $display("Fail test %0d: instruction length = 0x%0h, expected 0x%0h",
                   i_test_id, cyc + 1, i_exp_len);
          errs++;
        end
        if (errs == 0) begin
          $display("Test %0d opcode 0x%04h passed in %0d cycles", i_test_id, i_opcode, cyc + 1);
          pass_cnt++;
        end else begin
          $display("Test %0d opcode 0x%04h failed with %0d mismatches", i_test_id, i_opcode, errs);
          fail_cnt++;
        end
        open = 1'b0;
        done_cnt++;
      end
      cyc++;
    end
  end

endmodule

`default_nettype wire

// File: verification/tb_microcode_sequencer.sv
// Microcode sequencer testbench
// Runs a table of opcodes and flags through the sequencer and reports the results
`timescale 1ns/1ns
`default_nettype none

module tb_microcode_sequencer;
  import cpu_ctrl_pkg::*;

  localparam int INSTR_W        = 16;
  localparam int HOLD_CYCLES    = 12;
  localparam int TIMEOUT_CYCLES = 20;

  // Control word strobes run from MI in the top bit down to ADV just above the ALU field
  localparam logic [23:0] S_MI  = 24'h1 << 23;
  localparam logic [23:0] S_CO  = 24'h1 << 22;
  localparam logic [23:0] S_RO  = 24'h1 << 21;
  localparam logic [23:0] S_RI  = 24'h1 << 20;
  localparam logic [23:0] S_CE  = 24'h1 << 18;
  localparam logic [23:0] S_J   = 24'h1 << 17;
  localparam logic [23:0] S_ARI = 24'h1 << 16;
  localparam logic [23:0] S_ARO = 24'h1 << 15;
  localparam logic [23:0] S_BRI = 24'h1 << 14;
  localparam logic [23:0] S_BRO = 24'h1 << 13;
  localparam logic [23:0] S_CRI = 24'h1 << 12;
  localparam logic [23:0] S_CRO = 24'h1 << 11;
  localparam logic [23:0] S_TRI = 24'h1 << 10;
  localparam logic [23:0] S_TRO = 24'h1 << 9;
  localparam logic [23:0] S_OI  = 24'h1 << 8;
  localparam logic [23:0] S_EO  = 24'h1 << 7;
  localparam logic [23:0] S_EL  = 24'h1 << 6;
  localparam logic [23:0] S_HLT = 24'h1 << 5;
  localparam logic [23:0] S_ADV = 24'h1 << 4;

  // Shared step words for operand fetch, T-indirect addressing and the ALU operation
  localparam logic [23:0] OPERAND  = S_MI | S_CO | S_CE;
  localparam logic [23:0] INDIRECT = S_MI | S_TRO;
  localparam logic [23:0] ALU_STEP = S_EO | S_TRI | S_EL | S_ADV;

  typedef struct {
    logic [15:0] op;
    logic [2:0]  zco;
    logic [7:0]  len;
    logic [23:0] w2;
    logic [23:0] w3;
    logic [23:0] w4;
  } row_t;

  row_t rows[$];

  logic                      clk;
  logic                      rst_n;
  logic [INSTR_W-1:0]        instruction;
  logic                      zero;
  logic                      carry;
  logic                      odd;
  logic [STEP_W-1:0]         step;
  ctrl_word_t                control_word;
  int                        test_id;
  logic [7:0]                exp_len;
  logic [23:0]               exp_w2;
  logic [23:0]               exp_w3;
  logic [23:0]               exp_w4;
  int                        done;
  int                        passed;
  int                        failed;
  bit                        finished;

  microcode_sequencer #(.INSTR_W(INSTR_W)) microcode_sequencer_i (
    .i_clk          (clk),
    .i_rst_n        (rst_n),
    .i_instruction  (instruction),
    .i_zero         (zero),
    .i_carry        (carry),
    .i_odd          (odd),
    .o_step         (step),
    .o_control_word (control_word)
  );

  sequencer_monitor #(.HOLD_CYCLES(HOLD_CYCLES)) monitor_i (
    .i_clk     (clk),
    .i_step    (step),
    .i_word    (control_word),
    .i_opcode  (instruction),
    .i_test_id (test_id),
    .i_exp_len (exp_len),
    .i_exp_w2  (exp_w2),
    .i_exp_w3  (exp_w3),
    .i_exp_w4  (exp_w4),
    .o_done    (done),
    .o_passed  (passed),
    .o_failed  (failed)
  );

  bind microcode_sequencer sequencer_checker checker_i (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_step  (o_step),
    .i_word  (o_control_word)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic table_row(input logic [15:0] op, input logic [2:0] zco, input logic [7:0] len,
                           input logic [23:0] w2, input logic [23:0] w3, input logic [23:0] w4);
    rows.push_back('{op, zco, len, w2, w3, w4});
  endtask

  task automatic immediate_alu(input logic [15:0] op, input logic [3:0] alu);
    table_row(op, 3'b000, 8'd5, OPERAND, S_RO | S_TRI, ALU_STEP | 24'(alu));
  endtask

  task automatic register_alu(input logic [15:0] op, input logic [23:0] src,
                              input logic [3:0] alu);
    table_row(op, 3'b000, 8'd4, src | S_TRI, ALU_STEP | 24'(alu), '0);
  endtask

  task automatic single_alu(input logic [15:0] op, input logic [3:0] alu);
    table_row(op, 3'b000, 8'd3, ALU_STEP | 24'(alu), '0, '0);
  endtask

  // Flags are listed as zero, carry, odd
  task automatic build_table();
    table_row(OP_LD_A, 3'b000, 8'd4, OPERAND, S_RO | S_ARI | S_ADV, '0);
    table_row(OP_LDI_B, 3'b000, 8'd4, OPERAND, S_RO | S_BRI | S_ADV, '0);
    table_row(OP_LD_C, 3'b000, 8'd4, OPERAND, S_RO | S_CRI | S_ADV, '0);
    table_row(OP_ST_T, 3'b000, 8'd4, OPERAND, S_RI | S_TRO | S_ADV, '0);
    table_row(OP_ST_B, 3'b000, 8'd4, OPERAND, S_RI | S_BRO | S_ADV, '0);
    table_row(OP_LDT_C, 3'b000, 8'd4, INDIRECT, S_RO | S_CRI | S_ADV, '0);
    table_row(OP_STT_A, 3'b000, 8'd4, INDIRECT, S_RI | S_ARO | S_ADV, '0);
    table_row(OP_MOV_A_T, 3'b000, 8'd3, S_ARO | S_TRI | S_ADV, '0, '0);
    table_row(OP_MOV_B_C, 3'b000, 8'd3, S_BRO | S_CRI | S_ADV, '0, '0);
    table_row(OP_OUT_A, 3'b000, 8'd3, S_ARO | S_OI | S_ADV, '0, '0);
    table_row(OP_OUT_T, 3'b000, 8'd3, S_TRO | S_OI | S_ADV, '0, '0);
    table_row(OP_JMP, 3'b000, 8'd4, OPERAND, S_RO | S_J | S_ADV, '0);
    table_row(OP_JIZ, 3'b100, 8'd4, OPERAND, S_RO | S_J | S_ADV, '0);
    table_row(OP_JIZ, 3'b011, 8'd3, OPERAND | S_ADV, '0, '0);
    table_row(OP_JIC, 3'b010, 8'd4, OPERAND, S_RO | S_J | S_ADV, '0);
    table_row(OP_JIC, 3'b101, 8'd3, OPERAND | S_ADV, '0, '0);
    table_row(OP_JIO, 3'b001, 8'd4, OPERAND, S_RO | S_J | S_ADV, '0);
    table_row(OP_JIO, 3'b110, 8'd3, OPERAND | S_ADV, '0, '0);
    immediate_alu(OP_ADDI, ALU_ADD);
    immediate_alu(OP_SUBI, ALU_SUB);
    immediate_alu(OP_ANDI, ALU_AND);
    immediate_alu(OP_ORI, ALU_OR);
    immediate_alu(OP_XORI, ALU_XOR);
    register_alu(OP_ADD_B, S_BRO, ALU_ADD);
    register_alu(OP_SUB_C, S_CRO, ALU_SUB);
    register_alu(OP_AND_B, S_BRO, ALU_AND);
    register_alu(OP_OR_C, S_CRO, ALU_OR);
    register_alu(OP_XOR_B, S_BRO, ALU_XOR);
    single_alu(OP_SL, ALU_SL);
    single_alu(OP_SR, ALU_SR);
    single_alu(OP_ASR, ALU_ASR);
    single_alu(OP_ROL, ALU_ROL);
    single_alu(OP_ROR, ALU_ROR);
    single_alu(OP_ROLC, ALU_ROLC);
    single_alu(OP_RORC, ALU_RORC);
    single_alu(OP_INV, ALU_INV);
    single_alu(OP_NEG, ALU_NEG);
    single_alu(OP_CHK, ALU_CHK);
    // Unknown and former stack opcodes run as NOP
    table_row(16'h0000, 3'b000, 8'd3, S_ADV, '0, '0);
    table_row(16'h001a, 3'b000, 8'd3, S_ADV, '0, '0);
    table_row(16'h001f, 3'b000, 8'd3, S_ADV, '0, '0);
    table_row(16'h0025, 3'b000, 8'd3, S_ADV, '0, '0);
    // HLT stalls until reset, so it runs last with a length of zero
    table_row(OP_HLT, 3'b000, 8'd0, S_HLT, '0, '0);
  endtask

  task automatic apply_row(input int idx);
    instruction <= INSTR_W'(rows[idx].op);
    zero        <= rows[idx].zco[2];
    carry       <= rows[idx].zco[1];
    odd         <= rows[idx].zco[0];
    exp_len     <= rows[idx].len;
    exp_w2      <= rows[idx].w2;
    exp_w3      <= rows[idx].w3;
    exp_w4      <= rows[idx].w4;
    test_id     <= idx;
  endtask

  // The monitor counts a test as done on the cycle before the step returns to 0
  task automatic wait_finish(input int count, output bit ok);
    int n;
    ok = 1'b0;
    for (n = 0; n < TIMEOUT_CYCLES && !ok; n++) begin
      @(posedge clk);
      ok = (done == count);
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    instruction = '0;
    zero        = 1'b0;
    carry       = 1'b0;
    odd         = 1'b0;
    test_id     = -1;
    exp_len     = '0;
    exp_w2      = '0;
    exp_w3      = '0;
    exp_w4      = '0;
    finished    = 1'b1;
    build_table();
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < rows.size() && finished; i++) begin
      apply_row(i);
      wait_finish(i + 1, finished);
      if (!finished) begin
        $display("Timeout: test %0d did not finish within %0d cycles", i, TIMEOUT_CYCLES);
      end
    end
    @(negedge clk);
    $display("Tests %0d, passed %0d, failed %0d, assertion errors %0d",
             rows.size(), passed, failed, microcode_sequencer_i.checker_i.assert_errors);
    if (finished && failed == 0 && passed == rows.size() &&
        microcode_sequencer_i.checker_i.assert_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: microcode_sequencer.f
design/cpu_ctrl_pkg.sv
design/decode_if.sv
design/step_counter.sv
design/transfer_decoder.sv
design/alu_decoder.sv
design/branch_decoder.sv
design/microcode_sequencer.sv
verification/sequencer_checker.sv
verification/sequencer_monitor.sv
verification/tb_microcode_sequencer.sv
